//--- hdl/mem_pkg.sv
package mem_pkg;

    // Bus widths
    localparam int unsigned ADDR_W    = 32;
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned NUM_BYTES = DATA_W / 8;  // Byte lanes per word

    // Cache geometry, kept small so sets fill up fast
    localparam int unsigned NUM_SETS = 16;
    localparam int unsigned NUM_WAYS = 4;
    localparam int unsigned WAY_W    = $clog2(NUM_WAYS);

    // Address fields: | tag | set index | byte offset |
    localparam int unsigned OFFSET_W = 2;
    localparam int unsigned INDEX_W  = $clog2(NUM_SETS);
    localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // Per-way age counter, saturating
    localparam int unsigned AGE_W   = 2;
    localparam int unsigned AGE_MAX = NUM_WAYS - 1;

    // Backing store, 4 KB
    localparam int unsigned MEM_WORDS = 1024;
    localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);  // Address bits 11:2

    // Shared types
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [NUM_BYTES-1:0] be_t;

    // Power-up pattern seed, word k = base + 4k
    localparam data_t MEM_INIT_BASE = 32'h1000_0000;

    // Legal access sizes
    localparam be_t BE_BYTE = 4'b0001;
    localparam be_t BE_HALF = 4'b0011;
    localparam be_t BE_WORD = 4'b1111;

    // Load result for anything else
    localparam data_t BAD_SIZE_DATA = 32'hDEAD_BEEF;

endpackage

//--- hdl/l1_set_assoc_cache.sv
`timescale 1ns/1ps

module l1_set_assoc_cache (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           req_i,        // Legal access this cycle
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::data_t wr_data_i,
    input  mem_pkg::be_t   wr_mask_i,    // Zero on reads
    input  mem_pkg::data_t mem_word_i,   // Refill source on a miss
    output logic           hit_o,
    output mem_pkg::data_t rd_word_o     // Raw line word, not formatted
);

    // Storage per set and way
    logic [mem_pkg::TAG_W-1:0]    tag_q   [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];
    mem_pkg::data_t               data_q  [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];
    logic [mem_pkg::NUM_WAYS-1:0] valid_q [mem_pkg::NUM_SETS];
    logic [mem_pkg::AGE_W-1:0]    age_q   [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];

    // Address split
    logic [mem_pkg::TAG_W-1:0]   tag;
    logic [mem_pkg::INDEX_W-1:0] set_idx;

    // Lookup and replacement
    logic [mem_pkg::NUM_WAYS-1:0] way_hit;
    logic [mem_pkg::WAY_W-1:0]    hit_way;
    logic [mem_pkg::WAY_W-1:0]    victim_way;
    logic [mem_pkg::AGE_W-1:0]    victim_age;
    logic [mem_pkg::WAY_W-1:0]    use_way;    // Way that becomes youngest
    mem_pkg::data_t               fill_word;

    assign tag     = addr_i[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
    assign set_idx = addr_i[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];

    // Tag compare across all ways of the set
    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
            if (way_hit[w]) begin
                hit_way = mem_pkg::WAY_W'(w);  // At most one way matches
            end
        end
    end

    assign hit_o     = |way_hit;
    assign rd_word_o = hit_o ? data_q[set_idx][hit_way] : '0;

    // Victim = oldest way, lowest index on a tie
    always_comb begin
        victim_way = '0;
        victim_age = age_q[set_idx][0];
        for (int w = 1; w < mem_pkg::NUM_WAYS; w++) begin
            if (age_q[set_idx][w] > victim_age) begin  // Strict, keeps lower index
                victim_age = age_q[set_idx][w];
                victim_way = mem_pkg::WAY_W'(w);
            end
        end
    end

    assign use_way = hit_o ? hit_way : victim_way;

    // Refill word with write bytes merged in
    always_comb begin
        for (int b = 0; b < mem_pkg::NUM_BYTES; b++) begin
            fill_word[8*b +: 8] = wr_mask_i[b] ? wr_data_i[8*b +: 8]
                                               : mem_word_i[8*b +: 8];
        end
    end

    // Valid bits and LRU ages
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < mem_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (req_i) begin
            valid_q[set_idx][use_way] <= 1'b1;  // Already set on a hit
            for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
                if (mem_pkg::WAY_W'(w) == use_way) begin
                    age_q[set_idx][w] <= '0;  // Most recently used
                end else if (age_q[set_idx][w] < mem_pkg::AGE_W'(mem_pkg::AGE_MAX)) begin
                    age_q[set_idx][w] <= age_q[set_idx][w] + 1'b1;
                end
            end
        end
    end

    // Tags and line data
    always_ff @(posedge clk) begin
        if (req_i) begin
            if (hit_o) begin
                // Write hit, patch only the enabled lanes
                for (int b = 0; b < mem_pkg::NUM_BYTES; b++) begin
                    if (wr_mask_i[b]) begin
                        data_q[set_idx][hit_way][8*b +: 8] <= wr_data_i[8*b +: 8];
                    end
                end
            end else begin
                // Miss, allocate over the victim (reads and writes alike)
                tag_q[set_idx][victim_way]  <= tag;
                data_q[set_idx][victim_way] <= fill_word;
            end
        end
    end

endmodule

//--- hdl/backing_mem.sv
`timescale 1ns/1ps

module backing_mem (
    input  logic           clk,
    input  mem_pkg::addr_t addr_i,     // Only bits 11:2 decode
    input  mem_pkg::data_t wr_data_i,
    input  mem_pkg::be_t   wr_mask_i,  // Already gated by request and size
    output mem_pkg::data_t rd_word_o
);

    mem_pkg::data_t                mem_q [mem_pkg::MEM_WORDS];
    logic [mem_pkg::MEM_IDX_W-1:0] word_idx;

    // Known pattern at time zero, no reset on the array
    initial begin
        for (int k = 0; k < mem_pkg::MEM_WORDS; k++) begin
            mem_q[k] = mem_pkg::MEM_INIT_BASE + mem_pkg::DATA_W'(4 * k);
        end
    end

    assign word_idx  = addr_i[mem_pkg::OFFSET_W +: mem_pkg::MEM_IDX_W];
    assign rd_word_o = mem_q[word_idx];  // Combinational read

    // Write-through path, lane by lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < mem_pkg::NUM_BYTES; b++) begin
            if (wr_mask_i[b]) begin
                mem_q[word_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
        end
    end

endmodule

//--- hdl/access_unit.sv
`timescale 1ns/1ps

module access_unit (
    input  logic           req_i,
    input  logic           wr_en_i,
    input  mem_pkg::be_t   byte_en_i,
    input  logic           cache_hit_i,
    input  mem_pkg::data_t cache_word_i,
    input  mem_pkg::data_t mem_word_i,
    output logic           cache_req_o,  // Request with a legal size
    output mem_pkg::be_t   wr_mask_o,    // Common mask for cache and memory
    output logic           hit_o,
    output mem_pkg::data_t rd_data_o     // Formatted load result
);

    logic           size_byte;
    logic           size_half;
    logic           size_word;
    logic           size_ok;
    mem_pkg::data_t sel_word;

    // Size decode, only three codes are legal
    assign size_byte = (byte_en_i == mem_pkg::BE_BYTE);
    assign size_half = (byte_en_i == mem_pkg::BE_HALF);
    assign size_word = (byte_en_i == mem_pkg::BE_WORD);
    assign size_ok   = size_byte | size_half | size_word;

    assign cache_req_o = req_i & size_ok;
    assign wr_mask_o   = (cache_req_o && wr_en_i) ? byte_en_i : '0;

    // Illegal size never reports a hit
    assign hit_o = cache_req_o & cache_hit_i;

    // Line word on a hit, memory word otherwise
    assign sel_word = cache_hit_i ? cache_word_i : mem_word_i;

    // Zero-extend to the access size
    always_comb begin
        if (size_byte) begin
            rd_data_o = {{(mem_pkg::DATA_W-8){1'b0}}, sel_word[7:0]};
        end else if (size_half) begin
            rd_data_o = {{(mem_pkg::DATA_W-16){1'b0}}, sel_word[15:0]};
        end else if (size_word) begin
            rd_data_o = sel_word;
        end else begin
            rd_data_o = mem_pkg::BAD_SIZE_DATA;  // Rejected access
        end
    end

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           req_i,       // One access per cycle while high
    input  logic           wr_en_i,
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::data_t wr_data_i,
    input  mem_pkg::be_t   byte_en_i,
    output mem_pkg::data_t rd_data_o,
    output logic           hit_o
);

    logic           cache_req;
    mem_pkg::be_t   wr_mask;
    logic           cache_hit;
    mem_pkg::data_t cache_word;
    mem_pkg::data_t mem_word;

    // Size check, write mask and result select
    access_unit i_access_unit (
        .req_i        (req_i),
        .wr_en_i      (wr_en_i),
        .byte_en_i    (byte_en_i),
        .cache_hit_i  (cache_hit),
        .cache_word_i (cache_word),
        .mem_word_i   (mem_word),
        .cache_req_o  (cache_req),
        .wr_mask_o    (wr_mask),
        .hit_o        (hit_o),
        .rd_data_o    (rd_data_o)
    );

    // Cache and memory see the same request in the same cycle
    l1_set_assoc_cache i_cache (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (cache_req),
        .addr_i     (addr_i),
        .wr_data_i  (wr_data_i),
        .wr_mask_i  (wr_mask),
        .mem_word_i (mem_word),   // Refill data
        .hit_o      (cache_hit),
        .rd_word_o  (cache_word)
    );

    backing_mem i_mem (
        .clk       (clk),
        .addr_i    (addr_i),
        .wr_data_i (wr_data_i),
        .wr_mask_i (wr_mask),
        .rd_word_o (mem_word)
    );

endmodule

//--- verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int CLK_PERIOD   = 20;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - 2;  // 2 ns before the rising edge
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RAND     = 560;
    localparam int MAX_CYCLES   = 2000;  // About 3x reset + ~50 directed + random

    logic           clk;
    logic           rst_n_i;
    logic           req_i;
    logic           wr_en_i;
    mem_pkg::addr_t addr_i;
    mem_pkg::data_t wr_data_i;
    mem_pkg::be_t   byte_en_i;
    mem_pkg::data_t rd_data_o;
    logic           hit_o;

    // Reference state, same geometry as the cache
    mem_pkg::data_t            ref_mem   [mem_pkg::MEM_WORDS];
    logic [mem_pkg::TAG_W-1:0] ref_tag   [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];
    logic                      ref_valid [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];
    logic [mem_pkg::AGE_W-1:0] ref_age   [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];

    mem_pkg::data_t exp_data;
    logic           exp_hit;
    integer         seed;
    int             cycle_count;
    int             check_count;
    int             sent_count;

    mem_subsys_top i_dut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .wr_en_i   (wr_en_i),
        .addr_i    (addr_i),
        .wr_data_i (wr_data_i),
        .byte_en_i (byte_en_i),
        .rd_data_o (rd_data_o),
        .hit_o     (hit_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    function automatic logic size_legal(input mem_pkg::be_t be);
        return (be == mem_pkg::BE_BYTE) || (be == mem_pkg::BE_HALF) || (be == mem_pkg::BE_WORD);
    endfunction

    // Expected load result and hit flag for one request
    function automatic mem_pkg::data_t expected_load(input mem_pkg::addr_t addr,
                                                     input mem_pkg::be_t be,
                                                     output logic hit);
        logic [mem_pkg::INDEX_W-1:0] set_idx;
        logic [mem_pkg::TAG_W-1:0]   tag;
        mem_pkg::data_t              word;
        set_idx = addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
        tag     = addr[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
        word    = ref_mem[addr[mem_pkg::OFFSET_W +: mem_pkg::MEM_IDX_W]];  // Cache mirrors memory
        hit     = 1'b0;
        if (!size_legal(be)) begin
            return mem_pkg::BAD_SIZE_DATA;  // Rejected, never a hit
        end
        for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) begin
                hit = 1'b1;
            end
        end
        if (be == mem_pkg::BE_BYTE) begin
            return {24'h0, word[7:0]};
        end else if (be == mem_pkg::BE_HALF) begin
            return {16'h0, word[15:0]};
        end
        return word;
    endfunction

    // State update at the rising edge, LRU plus write-through
    task automatic commit_ref(input logic wr, input mem_pkg::addr_t addr,
                              input mem_pkg::data_t wdata, input mem_pkg::be_t be);
        logic [mem_pkg::INDEX_W-1:0]   set_idx;
        logic [mem_pkg::TAG_W-1:0]     tag;
        logic [mem_pkg::MEM_IDX_W-1:0] word_idx;
        int                            hit_w;
        int                            use_w;
        set_idx  = addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
        tag      = addr[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
        word_idx = addr[mem_pkg::OFFSET_W +: mem_pkg::MEM_IDX_W];
        if (size_legal(be)) begin
            hit_w = -1;
            for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
                if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) begin
                    hit_w = w;
                end
            end
            if (hit_w >= 0) begin
                use_w = hit_w;
            end else begin
                use_w = 0;  // Oldest way wins, lowest index on a tie
                for (int w = 1; w < mem_pkg::NUM_WAYS; w++) begin
                    if (ref_age[set_idx][w] > ref_age[set_idx][use_w]) begin
                        use_w = w;
                    end
                end
                ref_tag[set_idx][use_w]   = tag;
                ref_valid[set_idx][use_w] = 1'b1;
            end
            for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
                if (w == use_w) begin
                    ref_age[set_idx][w] = '0;
                end else if (ref_age[set_idx][w] < mem_pkg::AGE_W'(mem_pkg::AGE_MAX)) begin
                    ref_age[set_idx][w] = ref_age[set_idx][w] + 1'b1;  // Saturating
                end
            end
            if (wr) begin
                for (int b = 0; b < mem_pkg::NUM_BYTES; b++) begin
                    if (be[b]) begin
                        ref_mem[word_idx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end
        end
    endtask

    task automatic check_data(input string name, input mem_pkg::data_t got,
                              input mem_pkg::data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h (addr 0x%08h, be 0x%h)",
                     name, got, exp, addr_i, byte_en_i);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h (addr 0x%08h, be 0x%h)",
                     name, got, exp, addr_i, byte_en_i);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Compare each request late in its cycle, then advance the model
    initial begin
        forever begin
            @(negedge clk);
            #(SAMPLE_DELAY);
            if (rst_n_i && req_i) begin
                exp_data = expected_load(addr_i, byte_en_i, exp_hit);
                check_data("rd_data_o", rd_data_o, exp_data);
                check_hit("hit_o", hit_o, exp_hit);
                commit_ref(wr_en_i, addr_i, wr_data_i, byte_en_i);
                check_count++;
            end
        end
    end

    task automatic drive_access(input logic wr, input mem_pkg::addr_t addr,
                                input mem_pkg::data_t wdata, input mem_pkg::be_t be);
        @(negedge clk);
        req_i     = 1'b1;
        wr_en_i   = wr;
        addr_i    = addr;
        wr_data_i = wdata;
        byte_en_i = be;
        sent_count++;
    endtask

    task automatic load(input mem_pkg::addr_t addr, input mem_pkg::be_t be);
        drive_access(1'b0, addr, 32'h0, be);
    endtask

    task automatic store(input mem_pkg::addr_t addr, input mem_pkg::data_t wdata,
                         input mem_pkg::be_t be);
        drive_access(1'b1, addr, wdata, be);
    endtask

    // Addresses that all land in set 3
    function automatic mem_pkg::addr_t conflict_addr(input int i);
        return mem_pkg::addr_t'(32'h0000_000C + 32'h40 * i);
    endfunction

    initial begin
        int r;
        mem_pkg::be_t sizes [3];
        sizes[0]    = mem_pkg::BE_BYTE;
        sizes[1]    = mem_pkg::BE_HALF;
        sizes[2]    = mem_pkg::BE_WORD;
        seed        = 32'h1513;
        cycle_count = 0;
        check_count = 0;
        sent_count  = 0;
        rst_n_i     = 1'b0;
        req_i       = 1'b0;
        wr_en_i     = 1'b0;
        addr_i      = '0;
        wr_data_i   = '0;
        byte_en_i   = '0;
        for (int k = 0; k < mem_pkg::MEM_WORDS; k++) begin
            ref_mem[k] = mem_pkg::MEM_INIT_BASE + mem_pkg::data_t'(4 * k);
        end
        for (int s = 0; s < mem_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < mem_pkg::NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_age[s][w]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // Cold miss, then hits of every size
        load(32'h0000_0040, mem_pkg::BE_WORD);
        load(32'h0000_0040, mem_pkg::BE_WORD);
        load(32'h0000_0040, mem_pkg::BE_BYTE);
        load(32'h0000_0040, mem_pkg::BE_HALF);

        // Sized stores, including a write hit
        store(32'h0000_0080, 32'hFFFF_FFAB, mem_pkg::BE_BYTE);
        store(32'h0000_0084, 32'h7777_CDEF, mem_pkg::BE_HALF);
        store(32'h0000_0088, 32'h1234_5678, mem_pkg::BE_WORD);
        store(32'h0000_0040, 32'h0000_0099, mem_pkg::BE_BYTE);
        for (int a = 0; a < 4; a++) begin
            for (int z = 0; z < 3; z++) begin
                load(mem_pkg::addr_t'(32'h0000_0080 + 32'h4 * a), sizes[z]);  // a=3 is 0x8C, set 3
            end
        end
        load(32'h0000_0040, mem_pkg::BE_WORD);

        // LRU replacement in one set
        load(conflict_addr(0), mem_pkg::BE_WORD);
        store(conflict_addr(1), 32'hA1A1_A1A1, mem_pkg::BE_HALF);
        load(conflict_addr(2), mem_pkg::BE_WORD);
        load(conflict_addr(3), mem_pkg::BE_WORD);
        load(conflict_addr(0), mem_pkg::BE_WORD);  // Way of address 1 becomes oldest
        load(conflict_addr(4), mem_pkg::BE_WORD);  // Evicts address 1
        load(conflict_addr(1), mem_pkg::BE_WORD);  // Miss with merged memory data
        load(conflict_addr(0), mem_pkg::BE_WORD);
        load(conflict_addr(3), mem_pkg::BE_WORD);
        load(conflict_addr(4), mem_pkg::BE_WORD);
        load(conflict_addr(2), mem_pkg::BE_WORD);

        // Write miss allocates
        store(32'h0000_0200, 32'h0000_5A5A, mem_pkg::BE_HALF);
        load(32'h0000_0200, mem_pkg::BE_WORD);

        // Rejected sizes leave data and ages alone
        store(conflict_addr(0), 32'hFFFF_FFFF, 4'b0101);
        load(32'h0000_0300, 4'b0000);
        store(32'h0000_0300, 32'h1111_2222, 4'b1000);
        load(32'h0000_0300, mem_pkg::BE_WORD);  // Still a miss
        for (int i = 0; i < 6; i++) begin
            load(conflict_addr(5 - i), mem_pkg::BE_WORD);  // Miss first, victim shows the ages
        end

        // Random mix over 64 words
        for (int n = 0; n < NUM_RAND; n++) begin
            r = $random(seed);
            drive_access(r[12], {24'h0, r[5:0], 2'b00}, $random(seed),
                         (r[7:6] == 2'd3) ? r[11:8] : sizes[r[7:6]]);
        end

        @(negedge clk);
        req_i   = 1'b0;
        wr_en_i = 1'b0;
        @(negedge clk);  // Last request compared by now
        $display("%0d accesses compared", check_count);
        if (check_count == sent_count) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d accesses were compared", check_count, sent_count);
            $display("CHECKS FAILED");
            $fatal(1, "Accesses left unchecked");
        end
    end

endmodule

//--- files.f
hdl/mem_pkg.sv
hdl/l1_set_assoc_cache.sv
hdl/backing_mem.sv
hdl/access_unit.sv
hdl/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_mem_subsys -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
